// File: md_unit.f
hdl/md_pkg.sv
hdl/md_step_if.sv
hdl/md_ctrl.sv
hdl/md_cycle_counter.sv
hdl/md_mul_datapath.sv
hdl/md_div_datapath.sv
hdl/md_sign_unit.sv
hdl/md_unit.sv
verif/md_unit_tb.sv

// File: verif/md_unit_tb.sv
`timescale 1ns/10ps

module md_unit_tb;
    import md_pkg::*;

    localparam int N_STEPS   = 32;
    localparam int RST_CYC   = 16;
    localparam int N_TXN     = 250;   // all tests together, rounded up
    localparam int CYC_LIMIT = N_TXN * 40 + RST_CYC + 500;

    logic   clk;
    logic   rst_n;
    logic   req;
    md_op_t op;
    word_t  op_a;
    word_t  op_b;
    logic   ack;
    word_t  hi;
    word_t  lo;

    logic [31:0] lfsr;
    int          cycles = 0;

    md_unit #(
        .N_STEPS (N_STEPS)
    ) u_md_unit (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .op    (op),
        .op_a  (op_a),
        .op_b  (op_b),
        .ack   (ack),
        .hi    (hi),
        .lo    (lo)
    );

    always #10 clk = ~clk;   // 20 ns period

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYC_LIMIT)
        begin
            $display("Timeout after %0d cycles, the unit never acknowledged a request", cycles);
            $display("TESTBENCH FAILED");
            $fatal(1, "run aborted");
        end
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // galois form, taps of a maximal length polynomial
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v    = {v[MD_WIDTH-2:0], lfsr[0]};   // one step per bit
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    // expected {hi, lo}
    function automatic dword_t model(input md_op_t o, input word_t a, input word_t b);
        longint sa;
        longint sb;
        longint q;
        longint r;
        sa = $signed(a);
        sb = $signed(b);
        if (o == op_mult)
            return sa * sb;
        else if (o == op_multu)
            return dword_t'(a) * dword_t'(b);
        else if (b == '0)
            return {a, {MD_WIDTH{1'b1}}};   // divide by zero rule
        else if (o == op_div)
        begin
            q = sa / sb;   // truncates, remainder follows dividend
            r = sa % sb;
            return {r[MD_WIDTH-1:0], q[MD_WIDTH-1:0]};
        end
        return {a % b, a / b};
    endfunction

    // full four-phase transaction, lat counts cycles from the edge that samples req
    task automatic run_op(input md_op_t o, input word_t a, input word_t b, input int hold,
                          output word_t r_hi, output word_t r_lo, output int lat);
        @(posedge clk);
        op   <= o;
        op_a <= a;
        op_b <= b;
        req  <= 1'b1;
        @(posedge clk);
        lat = 0;
        @(negedge clk);
        while (!ack)
        begin
            lat++;
            @(negedge clk);
        end
        r_hi = hi;
        r_lo = lo;
        for (int i = 0; i < hold; i++)
        begin
            @(negedge clk);
            check("ack", ack, 1'b1);   // held in done
            check("hi", hi, r_hi);
            check("lo", lo, r_lo);
        end
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        check("ack", ack, 1'b1);
        @(negedge clk);
        check("ack", ack, 1'b0);   // falls one edge after req is seen low
    endtask

    task automatic check_op(input md_op_t o, input word_t a, input word_t b);
        word_t  r_hi;
        word_t  r_lo;
        int     lat;
        dword_t exp;
        run_op(o, a, b, 0, r_hi, r_lo, lat);
        exp = model(o, a, b);
        check("hi", r_hi, exp[2*MD_WIDTH-1:MD_WIDTH]);
        check("lo", r_lo, exp[MD_WIDTH-1:0]);
    endtask

    task automatic test_reset_latency();
        word_t r_hi;
        word_t r_lo;
        int    lat;
        @(negedge clk);
        check("ack", ack, 1'b0);
        check("hi", hi, '0);
        check("lo", lo, '0);
        run_op(op_multu, 32'd6, 32'd7, 0, r_hi, r_lo, lat);
        check("latency", lat, N_STEPS + 2);
        check("hi", r_hi, '0);
        check("lo", r_lo, 32'd42);
    endtask

    task automatic test_mult();
        md_op_t o;
        for (int k = 0; k < 2; k++)
        begin
            o = (k == 0) ? op_mult : op_multu;
            check_op(o, 32'd3, 32'd5);
            check_op(o, 32'hFFFF_FFFD, 32'd5);
            check_op(o, 32'd3, 32'hFFFF_FFFB);
            check_op(o, 32'hFFFF_FFFD, 32'hFFFF_FFFB);
            check_op(o, 32'd0, 32'h1234_5678);
            check_op(o, 32'd1, 32'hDEAD_BEEF);
            check_op(o, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
            check_op(o, 32'h8000_0000, 32'h8000_0000);   // most negative squared
            check_op(o, 32'h8000_0000, 32'd1);
            check_op(o, 32'h7FFF_FFFF, 32'h8000_0000);
        end
    endtask

    task automatic test_div();
        md_op_t o;
        for (int k = 0; k < 2; k++)
        begin
            o = (k == 0) ? op_div : op_divu;
            check_op(o, 32'd100, 32'd7);
            check_op(o, 32'hFFFF_FF9C, 32'd7);
            check_op(o, 32'd100, 32'hFFFF_FFF9);
            check_op(o, 32'hFFFF_FF9C, 32'hFFFF_FFF9);
            check_op(o, 32'h8000_0000, 32'hFFFF_FFFF);
            check_op(o, 32'd7, 32'd100);   // quotient zero
            check_op(o, 32'hFFFF_FFFF, 32'd1);
            check_op(o, 32'hDEAD_BEEF, 32'h0000_1234);
        end
    endtask

    task automatic test_div_zero();
        word_t r_hi;
        word_t r_lo;
        int    lat;
        run_op(op_div, 32'hFFFF_FFFB, 32'd0, 0, r_hi, r_lo, lat);
        check("lo", r_lo, 32'hFFFF_FFFF);
        check("hi", r_hi, 32'hFFFF_FFFB);
        run_op(op_divu, 32'h1234_5678, 32'd0, 0, r_hi, r_lo, lat);
        check("lo", r_lo, 32'hFFFF_FFFF);
        check("hi", r_hi, 32'h1234_5678);
    endtask

    task automatic test_back_pressure();
        word_t r_hi;
        word_t r_lo;
        int    lat;
        run_op(op_div, 32'hFFFF_FF9C, 32'd7, 10, r_hi, r_lo, lat);
        check("hi", r_hi, 32'hFFFF_FFFE);   // -100 / 7 leaves -2
        check("lo", r_lo, 32'hFFFF_FFF2);   // quotient -14
        check_op(op_mult, 32'h1234_5678, 32'h9ABC_DEF0);
    endtask

    task automatic test_random();
        md_op_t o;
        word_t  r;
        word_t  a;
        word_t  b;
        for (int n = 0; n < 200; n++)
        begin
            r = rand_bits(2);
            o = md_op_t'(r[1:0]);
            a = rand_bits(MD_WIDTH);
            b = rand_bits(MD_WIDTH);
            check_op(o, a, b);
        end
    endtask

    initial
    begin
        clk   = 1'b0;
        rst_n = 1'b0;
        req   = 1'b0;
        op    = op_mult;
        op_a  = '0;
        op_b  = '0;
        lfsr  = 32'h6861_2096;
        repeat (RST_CYC) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_latency();
        test_mult();
        test_div();
        test_div_zero();
        test_back_pressure();
        test_random();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: hdl/md_unit.sv
`timescale 1ns/10ps

module md_unit #(
    parameter int N_STEPS = md_pkg::MD_STEPS
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           req,
    input  md_pkg::md_op_t op,
    input  md_pkg::word_t  op_a,
    input  md_pkg::word_t  op_b,
    output logic           ack,
    output md_pkg::word_t  hi,
    output md_pkg::word_t  lo
);

    logic cnt_clear;
    logic cnt_en;
    logic cnt_last;

    md_step_if stp ();

    md_ctrl #(
        .N_STEPS   (N_STEPS)
    ) u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .ack       (ack),
        .cnt_clear (cnt_clear),
        .cnt_en    (cnt_en),
        .cnt_last  (cnt_last),
        .stp       (stp.ctrl)
    );

    md_cycle_counter #(
        .N_STEPS   (N_STEPS)
    ) u_cycle_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .cnt_clear (cnt_clear),
        .cnt_en    (cnt_en),
        .cnt_last  (cnt_last)
    );

    md_mul_datapath u_mul_datapath (
        .clk   (clk),
        .rst_n (rst_n),
        .stp   (stp.mul)
    );

    md_div_datapath u_div_datapath (
        .clk   (clk),
        .rst_n (rst_n),
        .stp   (stp.div)
    );

    md_sign_unit u_sign_unit (
        .clk   (clk),
        .rst_n (rst_n),
        .op    (op),
        .op_a  (op_a),
        .op_b  (op_b),
        .hi    (hi),
        .lo    (lo),
        .stp   (stp.sign)
    );

endmodule

// File: hdl/md_sign_unit.sv
`timescale 1ns/10ps

module md_sign_unit (
    input  logic           clk,
    input  logic           rst_n,
    input  md_pkg::md_op_t op,
    input  md_pkg::word_t  op_a,
    input  md_pkg::word_t  op_b,
    output md_pkg::word_t  hi,
    output md_pkg::word_t  lo,
    md_step_if.sign        stp
);
    import md_pkg::*;

    logic  is_signed;
    logic  sign_a;
    logic  sign_b;
    logic  sign_a_q;     // remainder sign
    logic  neg_q;        // product or quotient negative
    logic  div_zero_q;
    logic  pending;      // load seen, finish not yet
    word_t op_a_q;       // original dividend for divide by zero

    assign is_signed = (op == op_mult) || (op == op_div);
    assign sign_a    = is_signed & op_a[MD_WIDTH-1];
    assign sign_b    = is_signed & op_b[MD_WIDTH-1];
    assign stp.mag_a = sign_a ? -op_a : op_a;
    assign stp.mag_b = sign_b ? -op_b : op_b;

    always_ff @(posedge clk)
    begin
        if (stp.load)
        begin
            stp.op <= op;
            op_a_q <= op_a;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            sign_a_q   <= 1'b0;
            neg_q      <= 1'b0;
            div_zero_q <= 1'b0;
            pending    <= 1'b0;
            hi         <= '0;
            lo         <= '0;
        end
        else if (stp.load)
        begin
            sign_a_q   <= sign_a;
            neg_q      <= sign_a ^ sign_b;
            div_zero_q <= (op_b == '0);
            pending    <= 1'b1;
        end
        else if (stp.finish)
        begin
            pending <= 1'b0;
            case (stp.op)
                op_mult, op_multu:
                begin
                    {hi, lo} <= neg_q ? -stp.mul_raw : stp.mul_raw;
                end
                default:
                begin
                    if (div_zero_q)
                    begin
                        hi <= op_a_q;
                        lo <= '1;
                    end
                    else
                    begin
                        hi <= sign_a_q ? -stp.rem_raw : stp.rem_raw;
                        lo <= neg_q ? -stp.quo_raw : stp.quo_raw;
                    end
                end
            endcase
        end
    end

    // one operation in flight between load and finish
    a_no_overlap: assert property (
        @(posedge clk) disable iff (!rst_n)
        stp.load |-> !pending
    );

endmodule

// File: hdl/md_div_datapath.sv
`timescale 1ns/10ps

module md_div_datapath (
    input  logic   clk,
    input  logic   rst_n,
    md_step_if.div stp
);
    import md_pkg::*;

    dword_t rq;        // remainder high, dividend/quotient low
    word_t  divisor;

    logic [MD_WIDTH:0]   part;   // partial remainder after the shift
    logic [MD_WIDTH+1:0] diff;   // trial subtraction with borrow bit
    logic                fits;

    // remainder stays below the divisor, so the shifted value needs one extra bit
    assign part = rq[2*MD_WIDTH-1:MD_WIDTH-1];
    assign diff = {1'b0, part} - {2'b00, divisor};
    assign fits = !diff[MD_WIDTH+1];   // no borrow

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rq <= '0;
        end
        else if (stp.load)
        begin
            rq <= {{MD_WIDTH{1'b0}}, stp.mag_a};
        end
        else if (stp.step)
        begin
            if (fits)
                rq <= {diff[MD_WIDTH-1:0], rq[MD_WIDTH-2:0], 1'b1};
            else
                rq <= {part[MD_WIDTH-1:0], rq[MD_WIDTH-2:0], 1'b0};   // restore
        end
    end

    always_ff @(posedge clk)
    begin
        if (stp.load)
            divisor <= stp.mag_b;
    end

    // a zero divisor always fits, leaving all quotient bits set
    assign stp.quo_raw = rq[MD_WIDTH-1:0];
    assign stp.rem_raw = rq[2*MD_WIDTH-1:MD_WIDTH];

endmodule

// File: hdl/md_mul_datapath.sv
`timescale 1ns/10ps

module md_mul_datapath (
    input  logic   clk,
    input  logic   rst_n,
    md_step_if.mul stp
);
    import md_pkg::*;

    dword_t multiplicand;   // shifts left each step
    word_t  multiplier;     // shifts right each step
    dword_t acc;
    dword_t partial;

    // add the shifted multiplicand only for a set multiplier bit
    assign partial = multiplier[0] ? multiplicand : '0;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            acc        <= '0;
            multiplier <= '0;
        end
        else if (stp.load)
        begin
            acc        <= '0;
            multiplier <= stp.mag_b;
        end
        else if (stp.step)
        begin
            acc        <= acc + partial;
            multiplier <= {1'b0, multiplier[MD_WIDTH-1:1]};
        end
    end

    always_ff @(posedge clk)
    begin
        if (stp.load)
            multiplicand <= {{MD_WIDTH{1'b0}}, stp.mag_a};
        else if (stp.step)
            multiplicand <= {multiplicand[2*MD_WIDTH-2:0], 1'b0};
    end

    assign stp.mul_raw = acc;   // complete after the last step

endmodule

// File: hdl/md_cycle_counter.sv
`timescale 1ns/10ps

module md_cycle_counter #(
    parameter int N_STEPS = md_pkg::MD_STEPS
) (
    input  logic clk,
    input  logic rst_n,
    input  logic cnt_clear,
    input  logic cnt_en,
    output logic cnt_last
);
    import md_pkg::*;

    localparam step_cnt_t LAST = step_cnt_t'(N_STEPS - 1);

    step_cnt_t cnt;   // index of the current step

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            cnt <= '0;
        else if (cnt_clear)
            cnt <= '0;
        else if (cnt_en && !cnt_last)
            cnt <= cnt + 1'b1;   // holds at last index
    end

    assign cnt_last = (cnt == LAST);

    // no count request after the last step
    a_cnt_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (cnt_en && cnt_last) |=> !cnt_en
    );

endmodule

// File: hdl/md_ctrl.sv
`timescale 1ns/10ps

module md_ctrl #(
    parameter int N_STEPS = md_pkg::MD_STEPS
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    req,
    output logic    ack,
    output logic    cnt_clear,
    output logic    cnt_en,
    input  logic    cnt_last,
    md_step_if.ctrl stp
);
    import md_pkg::*;

    md_state_t state;
    md_state_t state_nxt;

    always_comb
    begin
        state_nxt = state;
        case (state)
            idle:
            begin
                if (req && !ack)
                    state_nxt = load;   // new request
            end
            load:
            begin
                state_nxt = run;
            end
            run:
            begin
                if (cnt_last)
                    state_nxt = finish;   // last iteration this cycle
            end
            finish:
            begin
                state_nxt = done;
            end
            done:
            begin
                if (!req)
                    state_nxt = idle;   // requester released
            end
            default:
            begin
                state_nxt = idle;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= idle;
            ack   <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            ack   <= (state_nxt == done);   // registered, follows state
        end
    end

    assign stp.load   = (state == load);
    assign stp.step   = (state == run);
    assign stp.finish = (state == finish);
    assign cnt_clear  = (state == load);   // counter starts at zero on first step
    assign cnt_en     = (state == run);

    // ack only while the result is held
    a_ack_in_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        ack |-> (state == done)
    );

    a_step_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        stp.step |-> !(stp.load || stp.finish)
    );

    // counter must end the run after exactly N_STEPS iterations
    a_run_length: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == load) |=> (state == run) [*N_STEPS] ##1 (state == finish)
    );

endmodule

// File: hdl/md_step_if.sv
`timescale 1ns/10ps

interface md_step_if;
    import md_pkg::*;

    logic   load;      // one cycle, datapaths initialise
    logic   step;      // one iteration per cycle
    logic   finish;    // results go to hi/lo
    md_op_t op;        // latched operation
    word_t  mag_a;     // operand magnitudes
    word_t  mag_b;
    dword_t mul_raw;   // unsigned product
    word_t  quo_raw;   // unsigned quotient
    word_t  rem_raw;   // unsigned remainder

    modport ctrl (
        output load, step, finish
    );

    modport sign (
        output mag_a, mag_b, op,
        input  load, finish, mul_raw, quo_raw, rem_raw
    );

    modport mul (
        input  load, step, mag_a, mag_b,
        output mul_raw
    );

    modport div (
        input  load, step, mag_a, mag_b,
        output quo_raw, rem_raw
    );

endinterface

// File: hdl/md_pkg.sv
package md_pkg;

    // operand width of the unit
    localparam int MD_WIDTH = 32;

    // one iteration per operand bit
    localparam int MD_STEPS = MD_WIDTH;

    typedef logic [MD_WIDTH-1:0]   word_t;    // operand or hi/lo half
    typedef logic [2*MD_WIDTH-1:0] dword_t;   // full product

    typedef logic [$clog2(MD_STEPS)-1:0] step_cnt_t;

    // encoding as seen on the op port
    typedef enum logic [1:0] {
        op_mult  = 2'b00,   // signed multiply
        op_multu = 2'b01,   // unsigned multiply
        op_div   = 2'b10,   // signed divide
        op_divu  = 2'b11    // unsigned divide
    } md_op_t;

    typedef enum logic [2:0] {
        idle   = 3'd0,
        load   = 3'd1,   // operands captured
        run    = 3'd2,   // iteration steps
        finish = 3'd3,   // sign fix into hi/lo
        done   = 3'd4    // ack held until req drops
    } md_state_t;

endpackage
